// File: all.f
+incdir+.
video_pkg.sv
vid_reg_decode.sv
vid_raster.sv
vid_reg_read.sv
video_gen.sv
tb_clock.sv
tb_video_gen.sv

// File: run.sh
#!/bin/bash
# build the video core testbench with Verilator and run it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
    --top-module tb_video_gen -f all.f \
    && ./obj_dir/Vtb_video_gen \
    || { echo "simulation run failed"; exit 1; }

// File: tb_clock.sv
////////////////////
// Testbench clock and reset
// 10 ns pixel clock, reset held for 8 cycles
////////////////////
`timescale 1ns/100ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;                             // released away from the sampling edge
    end

endmodule

// File: tb_checks.svh
////////////////////
// Raster and register model with typed compare tasks
////////////////////
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

coord_t      m_h_count;
coord_t      m_v_count;
sync_state_t m_v_state;
intr_t       m_intr;                                // expected interrupt pulse vector
logic        m_copp_wr;
reg_data_t   m_read;                                // expected read-back word
logic        m_read_valid;
color_t      sh_border;
coord_t      sh_cursor_x;
coord_t      sh_cursor_y;
coord_t      sh_top;
coord_t      sh_bottom;
coord_t      sh_left;
coord_t      sh_right;
reg_data_t   sh_copp;                               // masked copper control word
int          frames_done;

// pixels 0..15 are offscreen, 16..47 visible
function automatic sync_state_t h_state_of(input coord_t h);
    if (h < 11'd4) begin
        return PRE_SYNC;
    end else if (h < 11'd10) begin
        return SYNC;
    end else if (h < 11'd16) begin
        return POST_SYNC;
    end else begin
        return VISIBLE;
    end
endfunction

function automatic coord_t v_last_line(input sync_state_t st);
    case (st)
        VISIBLE:  return 11'd7;
        PRE_SYNC: return 11'd9;
        SYNC:     return 11'd11;
        default:  return 11'd13;
    endcase
endfunction

function automatic sync_state_t next_state(input sync_state_t st);
    case (st)
        PRE_SYNC:  return SYNC;
        SYNC:      return POST_SYNC;
        POST_SYNC: return VISIBLE;
        default:   return PRE_SYNC;
    endcase
endfunction

function automatic logic sync_level(input logic active, input logic polarity);
    return active ? polarity : ~polarity;
endfunction

function automatic reg_data_t expected_read(input reg_num_t num, input intr_t status);
    logic h_blank;
    logic v_blank;
    h_blank = (h_state_of(m_h_count) != VISIBLE);
    v_blank = (m_v_state != VISIBLE);
    case (num)
        XR_VID_CTRL:   return {sh_border, 4'h0, status};
        XR_COPP_CTRL:  return sh_copp;
        XR_CURSOR_X:   return {5'd0, sh_cursor_x};
        XR_CURSOR_Y:   return {5'd0, sh_cursor_y};
        XR_VID_TOP:    return {5'd0, sh_top};
        XR_VID_BOTTOM: return {5'd0, sh_bottom};
        XR_VID_LEFT:   return {5'd0, sh_left};
        XR_VID_RIGHT:  return {5'd0, sh_right};
        XR_SCANLINE:   return {v_blank, h_blank, 3'b000, m_v_count};
        XR_VERSION:    return VERSION_WORD;
        XR_VID_HSIZE:  return 16'd32;               // visible width
        XR_VID_VSIZE:  return 16'd8;                // visible height
        XR_VID_VFREQ:  return REFRESH_FREQ;
        default:       return 16'h0000;
    endcase
endfunction

task automatic model_reset();
    m_h_count    = '0;
    m_v_count    = '0;
    m_v_state    = PRE_SYNC;                        // first frame counts its early lines as pre-sync
    m_intr       = '0;
    m_copp_wr    = 1'b0;
    m_read       = '0;
    m_read_valid = 1'b0;
    sh_border    = BORDER_RESET;
    sh_cursor_x  = CURSOR_X_RESET;
    sh_cursor_y  = CURSOR_Y_RESET;
    sh_top       = '0;
    sh_bottom    = 11'd8;
    sh_left      = '0;
    sh_right     = 11'd32;
    sh_copp      = '0;
    frames_done  = 0;
endtask

// advance one clock edge with the inputs that edge samples
task automatic model_step(input logic wr, input reg_num_t num, input reg_data_t data,
                          input intr_t status);
    logic last_pixel;
    last_pixel = (m_h_count == 11'd47) && (m_v_state == VISIBLE) && (m_v_count == 11'd7);
    m_read       = expected_read(num, status);  // read sees state before this edge
    m_read_valid = 1'b1;
    m_intr       = last_pixel ? 4'b1000 : 4'b0000;
    m_copp_wr    = wr && (num == XR_COPP_CTRL);
    if (wr) begin
        case (num)
            XR_VID_CTRL: begin
                sh_border = data[15:8];
                m_intr    = m_intr | data[3:0];
            end
            XR_COPP_CTRL:  sh_copp = {data[15], 4'b0000, data[10:0]};
            XR_CURSOR_X:   sh_cursor_x = data[10:0];
            XR_CURSOR_Y:   sh_cursor_y = data[10:0];
            XR_VID_TOP:    sh_top = data[10:0];
            XR_VID_BOTTOM: sh_bottom = data[10:0];
            XR_VID_LEFT:   sh_left = data[10:0];
            XR_VID_RIGHT:  sh_right = data[10:0];
            default: begin
            end
        endcase
    end
    if (m_h_count == 11'd47) begin
        if (m_v_count == v_last_line(m_v_state)) begin
            m_v_state = next_state(m_v_state);
        end
        m_h_count = '0;
        if (m_v_count == 11'd13) begin
            m_v_count   = '0;
            frames_done = frames_done + 1;
        end else begin
            m_v_count = m_v_count + 11'd1;
        end
    end else begin
        m_h_count = m_h_count + 11'd1;
    end
endtask

task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR: %s is %h, expected %h", name, got, exp));
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR: %s is %h, expected %h", name, got, exp));
    end
endtask

task automatic check_intr(input string name, input intr_t got, input intr_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR: %s is %h, expected %h", name, got, exp));
    end
endtask

task automatic check_reg_data(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
        abort_run($sformatf("ERROR: %s is %h, expected %h", name, got, exp));
    end
endtask

`endif

// File: tb_video_gen.sv
////////////////////
// Video core testbench
// random register traffic against a raster and register model
////////////////////
`timescale 1ns/100ps

module tb_video_gen import video_pkg::*; ();

    localparam int RESET_LIMIT = 32;                // cycles allowed for reset release
    localparam int RUN_FRAMES  = 3;
    localparam int RUN_LIMIT   = 4 * int'(TOTAL_WIDTH) * int'(TOTAL_HEIGHT);

    logic      clk;
    logic      reset;
    logic      reg_wr;
    reg_num_t  reg_num;
    reg_data_t reg_data_wr;
    reg_data_t reg_data_rd;
    intr_t     intr_status;
    intr_t     intr_signal;
    logic      copp_reg_wr;
    reg_data_t copp_reg_data;
    coord_t    h_count;
    coord_t    v_count;
    logic      hsync;
    logic      vsync;
    logic      dv_de;
    logic      in_reset_q = 1'b1;                   // last rising edge was a reset edge
    int        seed;

    tb_clock u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    video_gen u_dut (
        .clk             (clk),
        .reset_i         (reset),
        .reg_wr_i        (reg_wr),
        .reg_num_i       (reg_num),
        .reg_data_i      (reg_data_wr),
        .reg_data_o      (reg_data_rd),
        .intr_status_i   (intr_status),
        .intr_signal_o   (intr_signal),
        .copp_reg_wr_o   (copp_reg_wr),
        .copp_reg_data_o (copp_reg_data),
        .h_count_o       (h_count),
        .v_count_o       (v_count),
        .hsync_o         (hsync),
        .vsync_o         (vsync),
        .dv_de_o         (dv_de)
    );

    always @(posedge clk) begin
        in_reset_q <= reset;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    `include "tb_checks.svh"

    task automatic check_outputs();
        check_coord("h_count_o", h_count, m_h_count);
        check_coord("v_count_o", v_count, m_v_count);
        check_bit("hsync_o", hsync, sync_level(h_state_of(m_h_count) == SYNC, H_SYNC_POLARITY));
        check_bit("vsync_o", vsync, sync_level(m_v_state == SYNC, V_SYNC_POLARITY));
        check_bit("dv_de_o", dv_de, (h_state_of(m_h_count) == VISIBLE) && (m_v_state == VISIBLE));
        check_intr("intr_signal_o", intr_signal, m_intr);
        check_bit("copp_reg_wr_o", copp_reg_wr, m_copp_wr);
        check_reg_data("copp_reg_data_o", copp_reg_data, sh_copp);
        if (m_read_valid) begin
            check_reg_data("reg_data_o", reg_data_rd, m_read);
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        if (in_reset_q) begin
            reg_wr      = 1'b0;
            reg_num     = '0;
            reg_data_wr = '0;
            intr_status = '0;
        end else begin
            r           = $random(seed);
            reg_wr      = (r[7:5] == 3'b000);       // about one write in eight
            reg_num     = reg_wr ? {2'b00, r[2:0]} : {1'b0, r[3:0]};
            reg_data_wr = r[31:16];
            intr_status = r[11:8];
        end
    endtask

    // called on each falling edge, outputs are settled there
    task automatic run_cycle();
        if (in_reset_q) begin
            model_reset();
        end else begin
            model_step(reg_wr, reg_num, reg_data_wr, intr_status);
        end
        check_outputs();
        drive_inputs();
    endtask

    initial begin
        int n;
        seed        = 46;
        reg_wr      = 1'b0;
        reg_num     = '0;
        reg_data_wr = '0;
        intr_status = '0;
        model_reset();

        n = 0;
        do begin
            @(negedge clk);
            run_cycle();
            n = n + 1;
            if (n > RESET_LIMIT) begin
                abort_run("reset was never released");
            end
        end while (in_reset_q);

        n = 0;
        while (frames_done < RUN_FRAMES) begin
            @(negedge clk);
            run_cycle();
            n = n + 1;
            if (n > RUN_LIMIT) begin
                abort_run("raster did not complete three frames in time");
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: vid_raster.sv
////////////////////
// Raster timing generator
// pixel and line counters, per axis sync FSMs, registered sync outputs
////////////////////
`default_nettype none
`timescale 1ns/100ps

module vid_raster import video_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    output      beam_t beam_o,                      // beam position for copper and status
    output      logic  last_visible_pixel_o,        // final visible pixel of the frame
    output      logic  hsync_o,
    output      logic  vsync_o,
    output      logic  dv_de_o                      // display enable
);

    sync_state_t h_state;
    sync_state_t v_state;
    sync_state_t h_state_next;
    sync_state_t v_state_next;

    coord_t h_count;
    coord_t v_count;
    coord_t h_count_next;
    coord_t v_count_next;
    coord_t h_end;                                  // last h_count of the current state
    coord_t v_end;                                  // last v_count of the current state

    logic line_end;
    logic frame_wrap;

    function automatic sync_state_t step_state(input sync_state_t st);
        return sync_state_t'(st + 2'd1);            // VISIBLE wraps back to PRE_SYNC
    endfunction

    // horizontal end points, offscreen pixels lead the line
    always_comb begin
        case (h_state)
            PRE_SYNC:  h_end = H_FRONT_PORCH - 1'b1;
            SYNC:      h_end = H_FRONT_PORCH + H_SYNC_PULSE - 1'b1;
            POST_SYNC: h_end = OFFSCREEN_WIDTH - 1'b1;
            default:   h_end = TOTAL_WIDTH - 1'b1;
        endcase
    end

    // vertical end points, offscreen lines trail the frame
    always_comb begin
        case (v_state)
            VISIBLE:   v_end = VISIBLE_HEIGHT - 1'b1;
            PRE_SYNC:  v_end = VISIBLE_HEIGHT + V_FRONT_PORCH - 1'b1;
            SYNC:      v_end = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_PULSE - 1'b1;
            default:   v_end = TOTAL_HEIGHT - 1'b1;
        endcase
    end

    assign line_end   = (h_state == VISIBLE) && (h_count == TOTAL_WIDTH - 1'b1);
    assign frame_wrap = line_end && (v_count == TOTAL_HEIGHT - 1'b1);

    assign h_state_next = (h_count == h_end) ? step_state(h_state) : h_state;
    assign v_state_next = (line_end && (v_count == v_end)) ? step_state(v_state) : v_state;

    assign last_visible_pixel_o = line_end && (v_state == VISIBLE) && (v_count == v_end);

    always_comb begin
        h_count_next = h_count + 1'b1;
        v_count_next = v_count;
        if (line_end) begin
            h_count_next = '0;
            v_count_next = frame_wrap ? '0 : v_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= PRE_SYNC;
            v_state <= PRE_SYNC;                    // first frame starts in pre-sync at line 0
            h_count <= '0;
            v_count <= '0;
            hsync_o <= ~H_SYNC_POLARITY;
            vsync_o <= ~V_SYNC_POLARITY;
            dv_de_o <= 1'b0;
        end else begin
            h_state <= h_state_next;
            v_state <= v_state_next;
            h_count <= h_count_next;
            v_count <= v_count_next;

            // outputs follow the next state so they line up with the counters
            hsync_o <= (h_state_next == SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= (v_state_next == SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o <= (h_state_next == VISIBLE) && (v_state_next == VISIBLE);
        end
    end

    assign beam_o.h_count = h_count;
    assign beam_o.v_count = v_count;
    assign beam_o.h_blank = (h_state != VISIBLE);
    assign beam_o.v_blank = (v_state != VISIBLE);

    assert property (@(posedge clk) disable iff (reset_i) h_count < TOTAL_WIDTH)
    else $error("h_count past end of line");

    // display enable and hsync come from different state decodes
    assert property (@(posedge clk) disable iff (reset_i)
        !(dv_de_o && (hsync_o == H_SYNC_POLARITY)))
    else $error("display enable during hsync");

endmodule
`default_nettype wire

// File: vid_reg_decode.sv
////////////////////
// Video register write decode
// holds the config, raises interrupt pulses and the copper strobe
////////////////////
`default_nettype none
`timescale 1ns/100ps

module vid_reg_decode import video_pkg::*; (
    input  wire logic      clk,
    input  wire logic      reset_i,
    input  wire logic      reg_wr_i,                // register write strobe
    input  wire reg_num_t  reg_num_i,
    input  wire reg_data_t reg_data_i,
    input  wire logic      last_visible_pixel_i,    // raster is on the final visible pixel
    output      vid_cfg_t  cfg_o,
    output      intr_t     intr_signal_o,           // one cycle interrupt request
    output      logic      copp_reg_wr_o,           // copper control write strobe
    output      reg_data_t copp_reg_data_o
);

    vid_cfg_t cfg_q;
    logic     copp_wr;

    assign copp_wr = reg_wr_i && (reg_num_i == XR_COPP_CTRL);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q.border_color <= BORDER_RESET;
            cfg_q.cursor_x     <= CURSOR_X_RESET;
            cfg_q.cursor_y     <= CURSOR_Y_RESET;
            cfg_q.vid_top      <= '0;
            cfg_q.vid_bottom   <= VISIBLE_HEIGHT;   // window covers the full screen
            cfg_q.vid_left     <= '0;
            cfg_q.vid_right    <= VISIBLE_WIDTH;
            cfg_q.copp_en      <= 1'b0;
            cfg_q.copp_addr    <= '0;
            intr_signal_o      <= '0;
            copp_reg_wr_o      <= 1'b0;
        end else begin
            intr_signal_o <= '0;                    // pulses last a single cycle
            copp_reg_wr_o <= copp_wr;

            if (reg_wr_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        cfg_q.border_color <= reg_data_i[15:8];
                        intr_signal_o      <= reg_data_i[3:0];  // software interrupt
                    end
                    XR_COPP_CTRL: begin
                        cfg_q.copp_en   <= reg_data_i[15];
                        cfg_q.copp_addr <= reg_data_i[COPPER_AWIDTH-1:0];
                    end
                    XR_CURSOR_X: begin
                        cfg_q.cursor_x <= reg_data_i[10:0];
                    end
                    XR_CURSOR_Y: begin
                        cfg_q.cursor_y <= reg_data_i[10:0];
                    end
                    XR_VID_TOP: begin
                        cfg_q.vid_top <= reg_data_i[10:0];
                    end
                    XR_VID_BOTTOM: begin
                        cfg_q.vid_bottom <= reg_data_i[10:0];
                    end
                    XR_VID_LEFT: begin
                        cfg_q.vid_left <= reg_data_i[10:0];
                    end
                    XR_VID_RIGHT: begin
                        cfg_q.vid_right <= reg_data_i[10:0];
                    end
                    default: begin
                    end
                endcase
            end

            // vsync interrupt merges with any write pulse
            if (last_visible_pixel_i) begin
                intr_signal_o[3] <= 1'b1;
            end
        end
    end

    assign cfg_o = cfg_q;

    // enable in bit 15, start address in the low bits
    assign copp_reg_data_o = {cfg_q.copp_en, {(15 - COPPER_AWIDTH){1'b0}}, cfg_q.copp_addr};

    // back to back copper strobes need back to back writes
    assert property (@(posedge clk) disable iff (reset_i)
        (copp_reg_wr_o && $past(copp_reg_wr_o)) |-> ($past(copp_wr, 1) && $past(copp_wr, 2)))
    else $error("copper strobe held without a second write");

endmodule
`default_nettype wire

// File: vid_reg_read.sv
////////////////////
// Video register read-back
// registered mux of config, beam status and constants
////////////////////
`default_nettype none
`timescale 1ns/100ps

module vid_reg_read import video_pkg::*; (
    input  wire logic      clk,
    input  wire reg_num_t  reg_num_i,               // register to show next cycle
    input  wire vid_cfg_t  cfg_i,
    input  wire beam_t     beam_i,
    input  wire intr_t     intr_status_i,           // pending interrupts
    output      reg_data_t reg_data_o
);

    always_ff @(posedge clk) begin
        case (reg_num_i)
            XR_VID_CTRL:   reg_data_o <= {cfg_i.border_color, 4'b0000, intr_status_i};
            XR_COPP_CTRL: begin
                reg_data_o <= {cfg_i.copp_en, {(15 - COPPER_AWIDTH){1'b0}}, cfg_i.copp_addr};
            end
            XR_CURSOR_X:   reg_data_o <= {5'b00000, cfg_i.cursor_x};
            XR_CURSOR_Y:   reg_data_o <= {5'b00000, cfg_i.cursor_y};
            XR_VID_TOP:    reg_data_o <= {5'b00000, cfg_i.vid_top};
            XR_VID_BOTTOM: reg_data_o <= {5'b00000, cfg_i.vid_bottom};
            XR_VID_LEFT:   reg_data_o <= {5'b00000, cfg_i.vid_left};
            XR_VID_RIGHT:  reg_data_o <= {5'b00000, cfg_i.vid_right};
            XR_SCANLINE: begin
                // blank flags on top, current line below
                reg_data_o <= {beam_i.v_blank, beam_i.h_blank, 3'b000, beam_i.v_count};
            end
            XR_VERSION:    reg_data_o <= VERSION_WORD;
            XR_VID_HSIZE:  reg_data_o <= {5'b00000, VISIBLE_WIDTH};
            XR_VID_VSIZE:  reg_data_o <= {5'b00000, VISIBLE_HEIGHT};
            XR_VID_VFREQ:  reg_data_o <= REFRESH_FREQ;
            default:       reg_data_o <= '0;        // unmapped numbers read as zero
        endcase
    end

endmodule
`default_nettype wire

// File: video_gen.sv
////////////////////
// Video controller scan core
// register decode, raster timing and read-back
////////////////////
`default_nettype none
`timescale 1ns/100ps

module video_gen import video_pkg::*; (
    input  wire logic      clk,                     // pixel clock
    input  wire logic      reset_i,
    input  wire logic      reg_wr_i,
    input  wire reg_num_t  reg_num_i,
    input  wire reg_data_t reg_data_i,
    output      reg_data_t reg_data_o,
    input  wire intr_t     intr_status_i,
    output      intr_t     intr_signal_o,
    output      logic      copp_reg_wr_o,
    output      reg_data_t copp_reg_data_o,
    output      coord_t    h_count_o,               // beam position for the copper
    output      coord_t    v_count_o,
    output      logic      hsync_o,
    output      logic      vsync_o,
    output      logic      dv_de_o
);

    vid_cfg_t cfg;
    beam_t    beam;
    logic     last_visible_pixel;

    vid_reg_decode u_decode (
        .clk                  (clk),
        .reset_i              (reset_i),
        .reg_wr_i             (reg_wr_i),
        .reg_num_i            (reg_num_i),
        .reg_data_i           (reg_data_i),
        .last_visible_pixel_i (last_visible_pixel),
        .cfg_o                (cfg),
        .intr_signal_o        (intr_signal_o),
        .copp_reg_wr_o        (copp_reg_wr_o),
        .copp_reg_data_o      (copp_reg_data_o)
    );

    vid_raster u_raster (
        .clk                  (clk),
        .reset_i              (reset_i),
        .beam_o               (beam),
        .last_visible_pixel_o (last_visible_pixel),
        .hsync_o              (hsync_o),
        .vsync_o              (vsync_o),
        .dv_de_o              (dv_de_o)
    );

    vid_reg_read u_read (
        .clk           (clk),
        .reg_num_i     (reg_num_i),
        .cfg_i         (cfg),
        .beam_i        (beam),
        .intr_status_i (intr_status_i),
        .reg_data_o    (reg_data_o)
    );

    assign h_count_o = beam.h_count;
    assign v_count_o = beam.v_count;

endmodule
`default_nettype wire

// File: video_pkg.sv
////////////////////
// Video controller shared definitions
// raster sizes, register map, vector types, sync states and bundles
////////////////////

package video_pkg;

    // beam and register word types
    typedef logic [10:0] coord_t;                       // beam coordinate or counter
    typedef logic [4:0]  reg_num_t;                     // config register number
    typedef logic [15:0] reg_data_t;                    // config register word
    typedef logic [7:0]  color_t;                       // palette index
    typedef logic [3:0]  intr_t;                        // interrupt vector

    localparam int COPPER_AWIDTH = 11;                  // copper program address bits

    typedef logic [COPPER_AWIDTH-1:0] copp_addr_t;      // copper start address

    // horizontal raster, offscreen pixels come first on each line
    localparam coord_t VISIBLE_WIDTH   = 11'd32;
    localparam coord_t H_FRONT_PORCH   = 11'd4;
    localparam coord_t H_SYNC_PULSE    = 11'd6;
    localparam coord_t H_BACK_PORCH    = 11'd6;
    localparam coord_t OFFSCREEN_WIDTH = 11'd16;        // front porch + sync + back porch
    localparam coord_t TOTAL_WIDTH     = 11'd48;

    // vertical raster, offscreen lines follow the visible ones
    localparam coord_t VISIBLE_HEIGHT  = 11'd8;
    localparam coord_t V_FRONT_PORCH   = 11'd2;
    localparam coord_t V_SYNC_PULSE    = 11'd2;
    localparam coord_t V_BACK_PORCH    = 11'd2;
    localparam coord_t TOTAL_HEIGHT    = 11'd14;

    localparam logic H_SYNC_POLARITY = 1'b0;            // active low hsync
    localparam logic V_SYNC_POLARITY = 1'b1;            // active high vsync

    localparam reg_data_t REFRESH_FREQ   = 16'h003C;    // nominal 60 Hz
    localparam reg_data_t VERSION_WORD   = 16'h0123;
    localparam color_t    BORDER_RESET   = 8'h08;       // dark grey so a live display is obvious
    localparam coord_t    CURSOR_X_RESET = 11'h180;
    localparam coord_t    CURSOR_Y_RESET = 11'h100;

    // register map
    localparam reg_num_t XR_VID_CTRL   = 5'd0;
    localparam reg_num_t XR_COPP_CTRL  = 5'd1;
    localparam reg_num_t XR_CURSOR_X   = 5'd2;
    localparam reg_num_t XR_CURSOR_Y   = 5'd3;
    localparam reg_num_t XR_VID_TOP    = 5'd4;
    localparam reg_num_t XR_VID_BOTTOM = 5'd5;
    localparam reg_num_t XR_VID_LEFT   = 5'd6;
    localparam reg_num_t XR_VID_RIGHT  = 5'd7;
    localparam reg_num_t XR_SCANLINE   = 5'd8;
    localparam reg_num_t XR_VERSION    = 5'd9;
    localparam reg_num_t XR_VID_HSIZE  = 5'd10;
    localparam reg_num_t XR_VID_VSIZE  = 5'd11;
    localparam reg_num_t XR_VID_VFREQ  = 5'd12;

    // each axis walks these in order and wraps from VISIBLE to PRE_SYNC
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'b00,
        SYNC      = 2'b01,
        POST_SYNC = 2'b10,
        VISIBLE   = 2'b11
    } sync_state_t;

    typedef struct packed {
        color_t     border_color;
        coord_t     cursor_x;
        coord_t     cursor_y;
        coord_t     vid_top;
        coord_t     vid_bottom;
        coord_t     vid_left;
        coord_t     vid_right;
        logic       copp_en;                            // copper run enable
        copp_addr_t copp_addr;
    } vid_cfg_t;

    typedef struct packed {
        coord_t h_count;
        coord_t v_count;
        logic   h_blank;                                // horizontal state not visible
        logic   v_blank;                                // vertical state not visible
    } beam_t;

endpackage
